// ==== muldiv_unit.f ====
arith_pkg.sv
mult_pipe.sv
div_core.sv
signed_div.sv
muldiv_unit.sv
tb_muldiv_unit.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile with Verilator, run, and decide the outcome from the log
rm -rf obj_dir sim.log
verilator --binary --timing --top-module tb_muldiv_unit -f muldiv_unit.f -o sim_muldiv_unit \
  && { ./obj_dir/sim_muldiv_unit > sim.log 2>&1; cat sim.log; grep -q "All tests passed" sim.log; } \
  && echo "Simulation PASSED" \
  || { echo "Simulation FAILED, see sim.log"; exit 1; }

// ==== tb_muldiv_unit.sv ====
// Self-checking testbench for WIDTH = DEFAULT_WIDTH only; stimulus table values assume 16-bit words
`timescale 1ns/1ps

module tb_muldiv_unit;

  localparam int W              = arith_pkg::DEFAULT_WIDTH;
  localparam int TABLE_ENTRIES  = 24;
  localparam int RANDOM_ENTRIES = 40;
  localparam int MAX_ENTRIES    = TABLE_ENTRIES + RANDOM_ENTRIES;
  localparam int CYCLE_LIMIT    = 50 * MAX_ENTRIES;

  typedef logic [W-1:0] word_t;

  logic           clk = 1'b0;
  logic           reset;
  logic           start;
  arith_pkg::op_t op;
  word_t          left;
  word_t          right;
  logic           ready;
  logic           done;
  word_t          result;
  word_t          remainder;

  // Stimulus columns and expected columns filled by the reference model
  arith_pkg::op_t tbl_op      [MAX_ENTRIES];
  word_t          tbl_left    [MAX_ENTRIES];
  word_t          tbl_right   [MAX_ENTRIES];
  logic           tbl_b2b     [MAX_ENTRIES];
  word_t          tbl_result  [MAX_ENTRIES];
  word_t          tbl_rem     [MAX_ENTRIES];
  int             tbl_latency [MAX_ENTRIES];
  int             n_entries = 0;

  // Results retire in issue order, so issued/retired act as a FIFO over the table
  int issue_cycle [MAX_ENTRIES];
  int issued           = 0;
  int retired          = 0;
  int cycle            = 0;
  int check_errors     = 0;
  int handshake_errors = 0;

  muldiv_unit #(
    .WIDTH(W)
  ) u_muldiv_unit (
    .clk      (clk),
    .reset    (reset),
    .start    (start),
    .op       (op),
    .left     (left),
    .right    (right),
    .ready    (ready),
    .done     (done),
    .result   (result),
    .remainder(remainder)
  );

  always #4 clk = ~clk;

  // Expected values from the arithmetic rules, computed on double-width words
  task automatic reference_model(input arith_pkg::op_t cmd, input word_t a, input word_t b,
                                 output word_t res, output word_t rem, output int lat);
    logic        [2*W-1:0] ua;
    logic        [2*W-1:0] ub;
    logic        [2*W-1:0] uw;
    logic signed [2*W-1:0] sa;
    logic signed [2*W-1:0] sb;
    logic signed [2*W-1:0] sq;
    logic signed [2*W-1:0] sr;
    ua  = {{W{1'b0}}, a};
    ub  = {{W{1'b0}}, b};
    sa  = {{W{a[W-1]}}, a};
    sb  = {{W{b[W-1]}}, b};
    res = '0;
    rem = '0;
    lat = 1;
    case (cmd)
      arith_pkg::OP_MUL: begin
        uw  = ua * ub;
        res = uw[W-1:0];
        lat = arith_pkg::MULT_STAGES;
      end
      arith_pkg::OP_DIVU: begin
        if (b != '0) begin
          uw  = ua / ub;
          res = uw[W-1:0];
          uw  = ua % ub;
          rem = uw[W-1:0];
          lat = W + 1;
        end
      end
      arith_pkg::OP_DIV: begin
        if (b != '0) begin
          sq = sa / sb;
          sr = sa % sb;
          // Remainder follows the divisor sign
          if ((sr != 0) && (sr[2*W-1] != sb[2*W-1])) begin
            sr = sr + sb;
          end
          res = sq[W-1:0];
          rem = sr[W-1:0];
          lat = W + 1;
        end
      end
      default: begin
        lat = 1;
      end
    endcase
  endtask

  task automatic add_entry(input arith_pkg::op_t cmd, input word_t a, input word_t b,
                           input logic b2b);
    word_t res;
    word_t rem;
    int    lat;
    reference_model(cmd, a, b, res, rem, lat);
    tbl_op[n_entries]      = cmd;
    tbl_left[n_entries]    = a;
    tbl_right[n_entries]   = b;
    tbl_b2b[n_entries]     = b2b;
    tbl_result[n_entries]  = res;
    tbl_rem[n_entries]     = rem;
    tbl_latency[n_entries] = lat;
    n_entries              = n_entries + 1;
  endtask

  task automatic build_table();
    // Multiplies with signs and overflow
    add_entry(arith_pkg::OP_MUL,  16'd3,     16'd5,     1'b0);
    add_entry(arith_pkg::OP_MUL,  16'hFFFE,  16'd7,     1'b0);
    add_entry(arith_pkg::OP_MUL,  16'h1234,  16'h5678,  1'b0);
    add_entry(arith_pkg::OP_MUL,  16'hFFFF,  16'hFFFF,  1'b0);
    add_entry(arith_pkg::OP_MUL,  16'h8000,  16'd2,     1'b0);
    // Three multiplies on consecutive cycles
    add_entry(arith_pkg::OP_MUL,  16'd100,   16'd200,   1'b0);
    add_entry(arith_pkg::OP_MUL,  16'h0102,  16'h0304,  1'b1);
    add_entry(arith_pkg::OP_MUL,  16'hFFFF,  16'd3,     1'b1);
    // Unsigned divisions
    add_entry(arith_pkg::OP_DIVU, 16'd100,   16'd7,     1'b0);
    add_entry(arith_pkg::OP_DIVU, 16'd5,     16'd9,     1'b0);
    add_entry(arith_pkg::OP_DIVU, 16'hFFFF,  16'd1,     1'b0);
    add_entry(arith_pkg::OP_DIVU, 16'hABCD,  16'h0010,  1'b0);
    add_entry(arith_pkg::OP_DIVU, 16'h8000,  16'hFFFF,  1'b0);
    // Signed divisions, all four sign combinations, then exact and extreme cases
    add_entry(arith_pkg::OP_DIV,  16'd7,     16'd2,     1'b0);
    add_entry(arith_pkg::OP_DIV,  16'hFFF9,  16'd2,     1'b0);
    add_entry(arith_pkg::OP_DIV,  16'd7,     16'hFFFE,  1'b0);
    add_entry(arith_pkg::OP_DIV,  16'hFFF9,  16'hFFFE,  1'b0);
    add_entry(arith_pkg::OP_DIV,  16'hFFEC,  16'd5,     1'b0);
    add_entry(arith_pkg::OP_DIV,  16'h8000,  16'hFFFF,  1'b0);
    // Zero divisors followed by normal commands
    add_entry(arith_pkg::OP_DIVU, 16'd1234,  16'd0,     1'b0);
    add_entry(arith_pkg::OP_DIV,  16'hFFFB,  16'd0,     1'b0);
    add_entry(arith_pkg::OP_MUL,  16'd6,     16'd7,     1'b1);
    add_entry(arith_pkg::OP_DIVU, 16'd50,    16'd5,     1'b1);
    // Multiply issued right behind a division has to wait for ready
    add_entry(arith_pkg::OP_MUL,  16'd9,     16'd11,    1'b1);
  endtask

  task automatic add_random_entries();
    logic [31:0]    a_rnd;
    logic [31:0]    b_rnd;
    int             sel;
    logic           b2b;
    arith_pkg::op_t cmd;
    a_rnd = $urandom(32'h5af868cf);
    for (int i = 0; i < RANDOM_ENTRIES; i++) begin
      sel   = $urandom % 3;
      a_rnd = $urandom;
      b_rnd = $urandom;
      // Small divisors half of the time, which also hits zero now and then
      if (($urandom % 2) == 1) begin
        b_rnd = b_rnd % 32;
      end
      b2b = (($urandom % 4) == 0);
      case (sel)
        0:       cmd = arith_pkg::OP_MUL;
        1:       cmd = arith_pkg::OP_DIV;
        default: cmd = arith_pkg::OP_DIVU;
      endcase
      // A zero divisor finishes in one cycle and would overtake a multiply in flight
      if ((cmd != arith_pkg::OP_MUL) && (b_rnd[W-1:0] == '0)) begin
        b2b = 1'b0;
      end
      add_entry(cmd, a_rnd[W-1:0], b_rnd[W-1:0], b2b);
    end
  endtask

  // Cycle counter and run limit
  always @(posedge clk) begin
    if (cycle >= CYCLE_LIMIT) begin
      $display("Timeout after %0d cycles with %0d of %0d commands retired",
               cycle, retired, n_entries);
      $display("Some tests failed");
      $finish;
    end else begin
      cycle <= cycle + 1;
    end
  end

  // Result checker, sampling at the falling edge where outputs are stable
  always @(negedge clk) begin : result_check
    int due;
    if (!reset) begin
      for (int k = retired; k < issued; k++) begin
        if ((tbl_op[k] != arith_pkg::OP_MUL) && (cycle > issue_cycle[k]) && ready) begin
          $display("ready was high at time %0t while division %0d was still running", $time, k);
          check_errors = check_errors + 1;
        end
      end
      if (done) begin
        if (retired >= issued) begin
          $display("Unexpected done at time %0t with no command outstanding", $time);
          check_errors = check_errors + 1;
        end else begin
          due = issue_cycle[retired] + tbl_latency[retired];
          if (result !== tbl_result[retired]) begin
            $display("MISMATCH at %0t: entry %0d result %h, expected %h",
                     $time, retired, result, tbl_result[retired]);
            check_errors = check_errors + 1;
          end
          if (remainder !== tbl_rem[retired]) begin
            $display("MISMATCH at %0t: entry %0d remainder %h, expected %h",
                     $time, retired, remainder, tbl_rem[retired]);
            check_errors = check_errors + 1;
          end
          if (cycle != due) begin
            $display("MISMATCH at %0t: entry %0d done in cycle %0d, expected cycle %0d",
                     $time, retired, cycle, due);
            check_errors = check_errors + 1;
          end
          retired = retired + 1;
        end
      end else if ((retired < issued) &&
                   (cycle > issue_cycle[retired] + tbl_latency[retired])) begin
        $display("No done at time %0t for entry %0d by its expected cycle", $time, retired);
        check_errors = check_errors + 1;
        retired = retired + 1;
      end
    end
  end

  // Driver
  initial begin
    int waited;
    reset = 1'b1;
    start = 1'b0;
    op    = arith_pkg::OP_MUL;
    left  = '0;
    right = '0;
    build_table();
    add_random_entries();

    repeat (10) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    if (!ready || done) begin
      $display("After reset ready should be high and done low, got ready=%b done=%b",
               ready, done);
      handshake_errors = handshake_errors + 1;
    end
    @(posedge clk);

    for (int i = 0; i < n_entries; i++) begin
      // Isolated commands wait for every earlier result first
      if (!tbl_b2b[i]) begin
        start <= 1'b0;
        while (retired != issued) @(posedge clk);
      end
      start  <= 1'b1;
      op     <= tbl_op[i];
      left   <= tbl_left[i];
      right  <= tbl_right[i];
      waited = 0;
      @(negedge clk);
      while (!ready) begin
        waited = waited + 1;
        @(negedge clk);
      end
      if (tbl_b2b[i] && (i > 0) && (tbl_op[i-1] == arith_pkg::OP_MUL) && (waited != 0)) begin
        $display("ready went low after the multiply before entry %0d", i);
        handshake_errors = handshake_errors + 1;
      end
      // Accept edge
      @(posedge clk);
      issue_cycle[i] = cycle;
      issued         = issued + 1;
    end
    start <= 1'b0;
    while (retired != issued) @(posedge clk);
    repeat (2) @(posedge clk);

    $display("Check errors: %0d, handshake errors: %0d, commands: %0d",
             check_errors, handshake_errors, n_entries);
    if ((check_errors + handshake_errors) == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// ==== muldiv_unit.sv ====
// Multiply/divide unit; one division at a time, results in issue order, receiver cannot stall
`timescale 1ns/1ps

module muldiv_unit #(
  parameter int WIDTH = arith_pkg::DEFAULT_WIDTH
) (
  input  logic             clk,
  input  logic             reset,
  input  logic             start,
  input  arith_pkg::op_t   op,
  input  logic [WIDTH-1:0] left,
  input  logic [WIDTH-1:0] right,
  output logic             ready,
  output logic             done,
  output logic [WIDTH-1:0] result,
  output logic [WIDTH-1:0] remainder
);

  typedef logic [WIDTH-1:0] word_t;

  logic  accept;
  logic  is_div;
  logic  mul_start;
  logic  div_start;
  logic  div_busy;

  word_t mul_product;
  logic  mul_done;
  word_t div_quotient;
  word_t div_remainder;
  logic  div_done;

  assign accept = start && ready;
  assign is_div = (op == arith_pkg::OP_DIV) || (op == arith_pkg::OP_DIVU);

  // Steer an accepted command to exactly one datapath
  assign mul_start = accept && (op == arith_pkg::OP_MUL);
  assign div_start = accept && is_div;

  // Busy from the accept edge through the cycle where the divider reports done
  always_ff @(posedge clk) begin
    if (reset) begin
      div_busy <= 1'b0;
    end else if (div_start) begin
      div_busy <= 1'b1;
    end else if (div_done) begin
      div_busy <= 1'b0;
    end
  end

  // Multiplies keep flowing while no division is outstanding
  assign ready = !div_busy;

  mult_pipe #(
    .WIDTH(WIDTH)
  ) u_mult_pipe (
    .clk    (clk),
    .reset  (reset),
    .start  (mul_start),
    .left   (left),
    .right  (right),
    .product(mul_product),
    .done   (mul_done)
  );

  signed_div #(
    .WIDTH(WIDTH)
  ) u_signed_div (
    .clk      (clk),
    .reset    (reset),
    .start    (div_start),
    .op       (op),
    .left     (left),
    .right    (right),
    .quotient (div_quotient),
    .remainder(div_remainder),
    .done     (div_done)
  );

  // The two datapaths never finish in the same cycle
  assign done      = mul_done | div_done;
  assign result    = mul_done ? mul_product : div_quotient;
  assign remainder = mul_done ? '0 : div_remainder;

endmodule

// ==== signed_div.sv ====
// Signed/unsigned divider around div_core; signed remainder follows the divisor sign
`timescale 1ns/1ps

module signed_div #(
  parameter int WIDTH = arith_pkg::DEFAULT_WIDTH
) (
  input  logic             clk,
  input  logic             reset,
  input  logic             start,
  input  arith_pkg::op_t   op,
  input  logic [WIDTH-1:0] left,
  input  logic [WIDTH-1:0] right,
  output logic [WIDTH-1:0] quotient,
  output logic [WIDTH-1:0] remainder,
  output logic             done
);

  typedef logic [WIDTH-1:0] word_t;

  logic  is_signed;
  word_t left_abs;
  word_t right_abs;

  // Operand signs and divisor magnitude captured at start
  logic  left_sign_q;
  logic  right_sign_q;
  word_t right_abs_q;

  word_t core_quotient;
  word_t core_remainder;
  logic  diff_signs;
  word_t rem_mag;

  assign is_signed = (op == arith_pkg::OP_DIV);

  // Unsigned operands pass straight through
  assign left_abs  = (is_signed && left[WIDTH-1]) ? -left : left;
  assign right_abs = (is_signed && right[WIDTH-1]) ? -right : right;

  always_ff @(posedge clk) begin
    if (reset) begin
      left_sign_q  <= 1'b0;
      right_sign_q <= 1'b0;
    end else if (start) begin
      left_sign_q  <= is_signed & left[WIDTH-1];
      right_sign_q <= is_signed & right[WIDTH-1];
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      right_abs_q <= right_abs;
    end
  end

  div_core #(
    .WIDTH(WIDTH)
  ) u_div_core (
    .clk      (clk),
    .reset    (reset),
    .start    (start),
    .dividend (left_abs),
    .divisor  (right_abs),
    .quotient (core_quotient),
    .remainder(core_remainder),
    .done     (done)
  );

  assign diff_signs = left_sign_q ^ right_sign_q;

  // Quotient truncates toward zero
  assign quotient = diff_signs ? -core_quotient : core_quotient;

  // Nonzero remainder with mixed signs wraps into the divisor's range
  assign rem_mag   = (diff_signs && (core_remainder != '0)) ? (right_abs_q - core_remainder)
                                                            : core_remainder;
  assign remainder = right_sign_q ? -rem_mag : rem_mag;

endmodule

// ==== div_core.sv ====
// Unsigned restoring divider taking WIDTH+1 cycles; a zero divisor returns 0/0 after one cycle
`timescale 1ns/1ps

module div_core #(
  parameter int WIDTH = arith_pkg::DEFAULT_WIDTH
) (
  input  logic             clk,
  input  logic             reset,
  input  logic             start,
  input  logic [WIDTH-1:0] dividend,
  input  logic [WIDTH-1:0] divisor,
  output logic [WIDTH-1:0] quotient,
  output logic [WIDTH-1:0] remainder,
  output logic             done
);

  typedef logic [WIDTH-1:0]   word_t;
  typedef logic [2*WIDTH-2:0] shifted_t;

  arith_pkg::div_state_t state;

  // Working registers for the iteration
  word_t    rem_q;
  word_t    quo_q;
  word_t    mask_q;
  shifted_t div_q;

  logic  load;
  logic  zero_div;
  logic  last_step;
  logic  fits;
  word_t rem_next;
  word_t quo_next;

  assign load      = (state == arith_pkg::DIV_IDLE) && start;
  assign zero_div  = (divisor == '0);
  assign last_step = mask_q[0];

  // Shifted divisor fits when it is not above the partial remainder
  assign fits     = (div_q <= {{(WIDTH-1){1'b0}}, rem_q});
  assign rem_next = fits ? (rem_q - div_q[WIDTH-1:0]) : rem_q;
  assign quo_next = fits ? (quo_q | mask_q) : quo_q;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= arith_pkg::DIV_IDLE;
    end else begin
      case (state)
        arith_pkg::DIV_IDLE: begin
          if (start) begin
            state <= zero_div ? arith_pkg::DIV_DONE : arith_pkg::DIV_RUN;
          end
        end
        arith_pkg::DIV_RUN: begin
          if (last_step) begin
            state <= arith_pkg::DIV_DONE;
          end
        end
        arith_pkg::DIV_DONE: begin
          state <= arith_pkg::DIV_IDLE;
        end
        default: begin
          state <= arith_pkg::DIV_IDLE;
        end
      endcase
    end
  end

  // Divisor starts aligned under the top dividend bit and walks down
  always_ff @(posedge clk) begin
    if (load) begin
      rem_q  <= dividend;
      quo_q  <= '0;
      mask_q <= {1'b1, {(WIDTH-1){1'b0}}};
      div_q  <= {divisor, {(WIDTH-1){1'b0}}};
    end else if (state == arith_pkg::DIV_RUN) begin
      rem_q  <= rem_next;
      quo_q  <= quo_next;
      mask_q <= mask_q >> 1;
      div_q  <= div_q >> 1;
    end
  end

  // Outputs update only at the end of an operation and hold afterwards
  always_ff @(posedge clk) begin
    if (load && zero_div) begin
      quotient  <= '0;
      remainder <= '0;
    end else if ((state == arith_pkg::DIV_RUN) && last_step) begin
      quotient  <= quo_next;
      remainder <= rem_next;
    end
  end

  assign done = (state == arith_pkg::DIV_DONE);

endmodule

// ==== mult_pipe.sv ====
// Fully pipelined multiplier keeping only the low WIDTH bits; depth is fixed at MULT_STAGES = 3
`timescale 1ns/1ps

module mult_pipe #(
  parameter int WIDTH = arith_pkg::DEFAULT_WIDTH
) (
  input  logic             clk,
  input  logic             reset,
  input  logic             start,
  input  logic [WIDTH-1:0] left,
  input  logic [WIDTH-1:0] right,
  output logic [WIDTH-1:0] product,
  output logic             done
);

  typedef logic [WIDTH-1:0]   word_t;
  typedef logic [2*WIDTH-1:0] wide_t;

  // One valid bit per pipeline stage
  logic [arith_pkg::MULT_STAGES-1:0] valid_q;

  word_t left_q;
  word_t right_q;
  wide_t full_q;

  // Valid bits shift every cycle so a new pair can enter each cycle
  always_ff @(posedge clk) begin
    if (reset) begin
      valid_q <= '0;
    end else begin
      valid_q <= {valid_q[arith_pkg::MULT_STAGES-2:0], start};
    end
  end

  // Stage one captures the operands
  always_ff @(posedge clk) begin
    if (start) begin
      left_q  <= left;
      right_q <= right;
    end
  end

  // Stage two forms the full unsigned product
  always_ff @(posedge clk) begin
    if (valid_q[0]) begin
      full_q <= wide_t'(left_q) * wide_t'(right_q);
    end
  end

  // Stage three keeps the low half, same for signed and unsigned operands
  always_ff @(posedge clk) begin
    if (valid_q[1]) begin
      product <= full_q[WIDTH-1:0];
    end
  end

  assign done = valid_q[arith_pkg::MULT_STAGES-1];

endmodule

// ==== arith_pkg.sv ====
// Shared command and state encodings; DEFAULT_WIDTH and MULT_STAGES must match the RTL pipeline depth
package arith_pkg;

  // Commands accepted by the multiply/divide unit
  typedef enum logic [1:0] {
    OP_MUL  = 2'd0,
    OP_DIV  = 2'd1,
    OP_DIVU = 2'd2
  } op_t;

  // Iterative divider states
  typedef enum logic [1:0] {
    DIV_IDLE = 2'd0,
    DIV_RUN  = 2'd1,
    DIV_DONE = 2'd2
  } div_state_t;

  // Operand width used unless the top level overrides it
  localparam int DEFAULT_WIDTH = 16;

  // Multiplier latency in cycles, from accept edge to done
  localparam int MULT_STAGES = 3;

endpackage
